/* include/mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Datapath and instruction width
`define MIPS_XLEN 32

// Memory depths in 32-bit words
`define MIPS_IMEM_WORDS 256
`define MIPS_DMEM_WORDS 256

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

/* hw/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// Primary opcode, bits 31:26
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LH    = 6'h21,
		OP_LW    = 6'h23,
		OP_LHU   = 6'h25,
		OP_SW    = 6'h2B
	} opcode_e;

	// R-type function code, bits 5:0
	typedef enum logic [5:0] {
		F_SLL  = 6'h00,
		F_SRL  = 6'h02,
		F_ADD  = 6'h20,
		F_SUB  = 6'h22,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_SLT  = 6'h2A,
		F_SLTU = 6'h2B
	} funct_e;

	typedef struct packed {
		opcode_e    opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} instr_t;

	// I-type immediate overlays rd, shamt and funct
	function automatic logic [15:0] instr_imm(instr_t instr);
		return {instr.rd, instr.shamt, instr.funct};
	endfunction

endpackage

`default_nettype wire

/* hw/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

	// Coarse ALU selection coming from the main decoder
	typedef enum logic [1:0] {
		AC_ADD   = 2'b00,
		AC_SUB   = 2'b01,
		AC_FUNCT = 2'b10
	} alu_class_e;

	// Load width and extension for data memory reads
	typedef enum logic [1:0] {
		HM_WORD     = 2'b00,
		HM_UNSIGNED = 2'b10,
		HM_SIGNED   = 2'b11
	} half_mode_e;

	// Operation actually carried out by the ALU
	typedef enum logic [3:0] {
		ALU_NONE,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLL,
		ALU_SRL,
		ALU_SLT,
		ALU_SLTU
	} alu_op_e;

	typedef struct packed {
		logic       reg_dest;
		logic       branch;
		logic       mem_to_reg;
		alu_class_e alu_class;
		logic       mem_write;
		logic       alu_src;
		logic       reg_write;
		half_mode_e half_mode;
	} ctrl_t;

endpackage

`default_nettype wire

/* hw/main_control.sv */
`default_nettype none

module main_control
	import isa_pkg::*, ctrl_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  opcode_e next_opcode,
	input  logic    fetch_valid,
	output ctrl_t   ex_ctrl
);

	ctrl_t decoded;

	// Opcode to control fields, everything off unless set below
	always_comb
	begin
		decoded = '0;
		case (next_opcode)
			OP_RTYPE:
			begin
				decoded.reg_dest  = 1'b1;
				decoded.alu_class = AC_FUNCT;
				decoded.reg_write = 1'b1;
			end
			OP_ADDI:
			begin
				decoded.alu_class = AC_ADD;
				decoded.alu_src   = 1'b1;
				decoded.reg_write = 1'b1;
			end
			OP_LW:
			begin
				decoded.mem_to_reg = 1'b1;
				decoded.alu_class  = AC_ADD;
				decoded.alu_src    = 1'b1;
				decoded.reg_write  = 1'b1;
				decoded.half_mode  = HM_WORD;
			end
			OP_LH:
			begin
				decoded.mem_to_reg = 1'b1;
				decoded.alu_class  = AC_ADD;
				decoded.alu_src    = 1'b1;
				decoded.reg_write  = 1'b1;
				decoded.half_mode  = HM_SIGNED;
			end
			OP_LHU:
			begin
				decoded.mem_to_reg = 1'b1;
				decoded.alu_class  = AC_ADD;
				decoded.alu_src    = 1'b1;
				decoded.reg_write  = 1'b1;
				decoded.half_mode  = HM_UNSIGNED;
			end
			OP_SW:
			begin
				decoded.alu_class = AC_ADD;
				decoded.mem_write = 1'b1;
				decoded.alu_src   = 1'b1;
			end
			OP_BEQ:
			begin
				// Compare by subtraction, zero flag decides
				decoded.branch    = 1'b1;
				decoded.alu_class = AC_SUB;
			end
			default:
			begin
				decoded = '0;
			end
		endcase
	end

	// Bubble while fetch is stalled
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			ex_ctrl <= '0;
		else if (!fetch_valid)
			ex_ctrl <= '0;
		else
			ex_ctrl <= decoded;
	end

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
`default_nettype none

`include "mips_config.svh"

module fetch_unit
	import isa_pkg::*;
(
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               run,
	input  logic                               imem_we,
	input  logic [$clog2(`MIPS_IMEM_WORDS)-1:0] imem_addr,
	input  logic [`MIPS_XLEN-1:0]              imem_data,
	input  logic                               branch_taken,
	input  logic [`MIPS_XLEN-1:0]              branch_target,
	output opcode_e                            next_opcode,
	output instr_t                             ex_instr,
	output logic [`MIPS_XLEN-1:0]              ex_pc_plus4
);

	localparam int IMEM_AW = $clog2(`MIPS_IMEM_WORDS);

	logic [`MIPS_XLEN-1:0] imem [`MIPS_IMEM_WORDS];
	logic [`MIPS_XLEN-1:0] pc;
	logic [`MIPS_XLEN-1:0] pc_plus4;
	logic [`MIPS_XLEN-1:0] fetch_word;

	// Word index from the byte program counter
	assign fetch_word  = imem[pc[IMEM_AW+1:2]];
	assign next_opcode = opcode_e'(fetch_word[31:26]);
	assign pc_plus4    = pc + `MIPS_XLEN'(4);

	// Program load port
	always_ff @(posedge clk)
	begin
		if (imem_we)
			imem[imem_addr] <= imem_data;
	end

	// Redirect lands after the delay slot has been fetched
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			pc <= `MIPS_RESET_PC;
		else if (run)
			pc <= branch_taken ? branch_target : pc_plus4;
	end

	// Captured on the same edge as the decoded control
	always_ff @(posedge clk)
	begin
		ex_instr    <= instr_t'(fetch_word);
		ex_pc_plus4 <= pc_plus4;
	end

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`default_nettype none

`include "mips_config.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [4:0]            rs_addr,
	input  logic [4:0]            rt_addr,
	output logic [`MIPS_XLEN-1:0] rs_data,
	output logic [`MIPS_XLEN-1:0] rt_data,
	input  logic                  we,
	input  logic [4:0]            wr_addr,
	input  logic [`MIPS_XLEN-1:0] wr_data,
	input  logic [4:0]            dbg_addr,
	output logic [`MIPS_XLEN-1:0] dbg_data
);

	logic [`MIPS_XLEN-1:0] regs [32];

	// Register 0 is never written so it stays at its reset value
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			regs <= '{default: '0};
		else if (we && (wr_addr != 5'd0))
			regs[wr_addr] <= wr_data;
	end

	assign rs_data  = regs[rs_addr];
	assign rt_data  = regs[rt_addr];

	// Debug read for the testbench
	assign dbg_data = regs[dbg_addr];

endmodule

`default_nettype wire

/* hw/alu.sv */
`default_nettype none

`include "mips_config.svh"

module alu
	import isa_pkg::*, ctrl_pkg::*;
(
	input  alu_class_e            alu_class,
	input  funct_e                funct,
	input  logic [4:0]            shamt,
	input  logic [`MIPS_XLEN-1:0] a,
	input  logic [`MIPS_XLEN-1:0] b,
	output logic [`MIPS_XLEN-1:0] result,
	output logic                  zero
);

	alu_op_e op;

	// Operation select
	always_comb
	begin
		case (alu_class)
			AC_ADD:   op = ALU_ADD;
			AC_SUB:   op = ALU_SUB;
			AC_FUNCT:
			begin
				case (funct)
					F_ADD:   op = ALU_ADD;
					F_SUB:   op = ALU_SUB;
					F_AND:   op = ALU_AND;
					F_OR:    op = ALU_OR;
					F_SLL:   op = ALU_SLL;
					F_SRL:   op = ALU_SRL;
					F_SLT:   op = ALU_SLT;
					F_SLTU:  op = ALU_SLTU;
					default: op = ALU_NONE;
				endcase
			end
			default:  op = ALU_NONE;
		endcase
	end

	always_comb
	begin
		case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			// Shifts move rt by the instruction shamt
			ALU_SLL:  result = b << shamt;
			ALU_SRL:  result = b >> shamt;
			ALU_SLT:  result = `MIPS_XLEN'($signed(a) < $signed(b));
			ALU_SLTU: result = `MIPS_XLEN'(a < b);
			default:  result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

/* hw/data_mem.sv */
`default_nettype none

`include "mips_config.svh"

module data_mem
	import ctrl_pkg::*;
(
	input  logic                  clk,
	input  logic                  mem_write,
	input  half_mode_e            half_mode,
	input  logic [`MIPS_XLEN-1:0] addr,
	input  logic [`MIPS_XLEN-1:0] wr_data,
	output logic [`MIPS_XLEN-1:0] load_data
);

	localparam int DMEM_AW = $clog2(`MIPS_DMEM_WORDS);

	logic [`MIPS_XLEN-1:0] mem [`MIPS_DMEM_WORDS];
	logic [DMEM_AW-1:0]    word_idx;
	logic [`MIPS_XLEN-1:0] word;
	logic [15:0]           half;

	// Byte address to word index
	assign word_idx = addr[DMEM_AW+1:2];
	assign word     = mem[word_idx];

	// Little-endian, bit 1 picks the upper half
	assign half = addr[1] ? word[31:16] : word[15:0];

	always_ff @(posedge clk)
	begin
		if (mem_write)
			mem[word_idx] <= wr_data;
	end

	always_comb
	begin
		case (half_mode)
			HM_SIGNED:   load_data = {{(`MIPS_XLEN-16){half[15]}}, half};
			HM_UNSIGNED: load_data = {{(`MIPS_XLEN-16){1'b0}}, half};
			default:     load_data = word;
		endcase
	end

endmodule

`default_nettype wire

/* hw/mips_core.sv */
`default_nettype none

`include "mips_config.svh"

module mips_core
	import isa_pkg::*, ctrl_pkg::*;
(
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               run,
	input  logic                               imem_we,
	input  logic [$clog2(`MIPS_IMEM_WORDS)-1:0] imem_addr,
	input  logic [`MIPS_XLEN-1:0]              imem_data,
	input  logic [4:0]                         dbg_addr,
	output logic [`MIPS_XLEN-1:0]              dbg_data
);

	opcode_e               next_opcode;
	ctrl_t                 ex_ctrl;
	instr_t                ex_instr;
	logic [`MIPS_XLEN-1:0] ex_pc_plus4;
	logic                  branch_taken;
	logic [`MIPS_XLEN-1:0] branch_target;
	logic [`MIPS_XLEN-1:0] rs_data;
	logic [`MIPS_XLEN-1:0] rt_data;
	logic [15:0]           imm;
	logic [`MIPS_XLEN-1:0] imm_ext;
	logic [`MIPS_XLEN-1:0] alu_b;
	logic [`MIPS_XLEN-1:0] alu_result;
	logic                  alu_zero;
	logic [`MIPS_XLEN-1:0] load_data;
	logic [4:0]            wr_addr;
	logic [`MIPS_XLEN-1:0] wr_data;

	main_control u_main_control (
		.clk         (clk),
		.reset       (reset),
		.next_opcode (next_opcode),
		.fetch_valid (run),
		.ex_ctrl     (ex_ctrl)
	);

	fetch_unit u_fetch_unit (
		.clk           (clk),
		.reset         (reset),
		.run           (run),
		.imem_we       (imem_we),
		.imem_addr     (imem_addr),
		.imem_data     (imem_data),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.next_opcode   (next_opcode),
		.ex_instr      (ex_instr),
		.ex_pc_plus4   (ex_pc_plus4)
	);

	// Execute stage muxes
	assign imm     = instr_imm(ex_instr);
	assign imm_ext = {{(`MIPS_XLEN-16){imm[15]}}, imm};
	assign alu_b   = ex_ctrl.alu_src ? imm_ext : rt_data;
	assign wr_addr = ex_ctrl.reg_dest ? ex_instr.rd : ex_instr.rt;
	assign wr_data = ex_ctrl.mem_to_reg ? load_data : alu_result;

	// Branch offset counts words from the delay slot
	assign branch_taken  = ex_ctrl.branch & alu_zero;
	assign branch_target = ex_pc_plus4 + (imm_ext << 2);

	reg_file u_reg_file (
		.clk      (clk),
		.reset    (reset),
		.rs_addr  (ex_instr.rs),
		.rt_addr  (ex_instr.rt),
		.rs_data  (rs_data),
		.rt_data  (rt_data),
		.we       (ex_ctrl.reg_write),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.dbg_addr (dbg_addr),
		.dbg_data (dbg_data)
	);

	alu u_alu (
		.alu_class (ex_ctrl.alu_class),
		.funct     (ex_instr.funct),
		.shamt     (ex_instr.shamt),
		.a         (rs_data),
		.b         (alu_b),
		.result    (alu_result),
		.zero      (alu_zero)
	);

	data_mem u_data_mem (
		.clk       (clk),
		.mem_write (ex_ctrl.mem_write),
		.half_mode (ex_ctrl.half_mode),
		.addr      (alu_result),
		.wr_data   (rt_data),
		.load_data (load_data)
	);

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`default_nettype none

module tb_clock (
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	// 100 ns period
	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Active-low reset for the first ten cycles, released on a falling edge
	initial
	begin
		reset = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;
	end

endmodule

`default_nettype wire

/* verif/tb_mips_core.sv */
`default_nettype none

`include "mips_config.svh"

module tb_mips_core
	import isa_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	logic                               clk;
	logic                               reset;
	logic                               run;
	logic                               imem_we;
	logic [$clog2(`MIPS_IMEM_WORDS)-1:0] imem_addr;
	logic [`MIPS_XLEN-1:0]              imem_data;
	logic [4:0]                         dbg_addr;
	logic [`MIPS_XLEN-1:0]              dbg_data;

	// Reference model state
	logic [31:0] model_regs [32];
	logic [31:0] model_dmem [`MIPS_DMEM_WORDS];
	logic [31:0] model_imem [`MIPS_IMEM_WORDS];
	logic [31:0] model_pc;
	logic [31:0] model_npc;
	logic [31:0] prog [$];

	integer seed;
	int     error_count;
	int     test_errors;
	int     tests_run;
	string  test_name;

	tb_clock u_clock (
		.clk   (clk),
		.reset (reset)
	);

	mips_core u_dut (
		.clk       (clk),
		.reset     (reset),
		.run       (run),
		.imem_we   (imem_we),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.dbg_addr  (dbg_addr),
		.dbg_data  (dbg_data)
	);

	function automatic logic [31:0] encode_r(funct_e f, int rs, int rt, int rd, int sh);
		return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), f};
	endfunction

	function automatic logic [31:0] encode_i(opcode_e op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] rtype_result(logic [5:0] fn, logic [31:0] a,
		logic [31:0] b, logic [4:0] sh);
		case (fn)
			F_ADD:   return a + b;
			F_SUB:   return a - b;
			F_AND:   return a & b;
			F_OR:    return a | b;
			F_SLL:   return b << sh;
			F_SRL:   return b >> sh;
			F_SLT:   return {31'b0, $signed(a) < $signed(b)};
			F_SLTU:  return {31'b0, a < b};
			default: return 32'h0;
		endcase
	endfunction

	task automatic write_model_reg(logic [4:0] r, logic [31:0] v);
		if (r != 5'd0)
			model_regs[r] = v;
	endtask

	// One instruction of the ISA, with a single delay slot after beq
	task automatic model_step();
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sext;
		logic [31:0] addr;
		logic [31:0] word;
		logic [15:0] half;
		ins  = model_imem[(model_pc >> 2) % `MIPS_IMEM_WORDS];
		a    = model_regs[ins[25:21]];
		b    = model_regs[ins[20:16]];
		sext = {{16{ins[15]}}, ins[15:0]};
		addr = a + sext;
		word = model_dmem[(addr >> 2) % `MIPS_DMEM_WORDS];
		half = addr[1] ? word[31:16] : word[15:0];
		model_pc  = model_npc;
		model_npc = model_npc + 32'd4;
		case (ins[31:26])
			OP_RTYPE: write_model_reg(ins[15:11], rtype_result(ins[5:0], a, b, ins[10:6]));
			OP_ADDI:  write_model_reg(ins[20:16], addr);
			OP_LW:    write_model_reg(ins[20:16], word);
			OP_LH:    write_model_reg(ins[20:16], {{16{half[15]}}, half});
			OP_LHU:   write_model_reg(ins[20:16], {16'h0, half});
			OP_SW:    model_dmem[(addr >> 2) % `MIPS_DMEM_WORDS] = b;
			OP_BEQ:
			begin
				// model_pc already points at the delay slot
				if (a == b)
					model_npc = model_pc + (sext << 2);
			end
			default:
			begin
			end
		endcase
	endtask

	task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("Mismatch in %s %s: expected %h, actual %h",
				test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic start_test(string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		if (test_errors == 0)
			$display("Test %s: ok", test_name);
		else
			$display("Test %s: %0d error(s)", test_name, test_errors);
		error_count += test_errors;
		tests_run++;
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (reset !== 1'b1 && cycles < 40)
		begin
			@(posedge clk);
			cycles++;
		end
		if (reset !== 1'b1)
		begin
			$display("Reset was not released within %0d cycles", cycles);
			error_count++;
		end
		@(negedge clk);
	endtask

	// Program goes in at the word the core will fetch next
	task automatic load_program();
		int base;
		base = (model_pc >> 2) % `MIPS_IMEM_WORDS;
		foreach (prog[i])
		begin
			@(negedge clk);
			imem_we   = 1'b1;
			imem_addr = 8'(base + i);
			imem_data = prog[i];
			model_imem[(base + i) % `MIPS_IMEM_WORDS] = prog[i];
		end
		@(negedge clk);
		imem_we   = 1'b0;
		model_npc = model_pc + 32'd4;
	endtask

	task automatic run_instructions(int count);
		int issued;
		int cycles;
		issued = 0;
		cycles = 0;
		repeat (count)
			model_step();
		run = 1'b1;
		while (issued < count && cycles < count + 20)
		begin
			@(posedge clk);
			cycles++;
			if (reset === 1'b1)
				issued++;
		end
		@(negedge clk);
		run = 1'b0;
		// Last fetched instruction still writes back on the next edge
		@(posedge clk);
		@(negedge clk);
		if (issued < count)
		begin
			$display("Timeout in %s: %0d of %0d instructions issued", test_name, issued, count);
			test_errors++;
		end
	endtask

	task automatic check_registers();
		for (int r = 0; r < 32; r++)
		begin
			@(negedge clk);
			dbg_addr = 5'(r);
			#1;
			check_value($sformatf("r%0d", r), model_regs[r], dbg_data);
		end
	endtask

	task automatic execute_and_check(int count);
		load_program();
		run_instructions(count);
		check_registers();
	endtask

	task automatic test_reset_state();
		start_test("reset_state");
		check_registers();
		finish_test();
	endtask

	task automatic test_arith();
		logic [15:0] imm [4];
		start_test("arith");
		for (int i = 0; i < 4; i++)
			imm[i] = 16'($random(seed));
		// One negative and one positive operand for the compares
		imm[0][15] = 1'b1;
		imm[1][15] = 1'b0;
		prog.delete();
		for (int i = 0; i < 4; i++)
			prog.push_back(encode_i(OP_ADDI, 0, i + 1, imm[i]));
		prog.push_back(encode_r(F_ADD, 1, 2, 5, 0));
		prog.push_back(encode_r(F_SUB, 3, 4, 6, 0));
		prog.push_back(encode_r(F_AND, 1, 3, 7, 0));
		prog.push_back(encode_r(F_OR, 2, 4, 8, 0));
		prog.push_back(encode_r(F_SLT, 1, 2, 9, 0));
		prog.push_back(encode_r(F_SLTU, 1, 2, 10, 0));
		prog.push_back(encode_r(F_SLT, 2, 1, 11, 0));
		prog.push_back(encode_r(F_SLTU, 2, 1, 12, 0));
		execute_and_check(prog.size());
		finish_test();
	endtask

	task automatic test_shifts();
		logic [15:0] imm;
		int          shamts [4];
		start_test("shifts");
		shamts = '{0, 5, 16, 31};
		imm = 16'($random(seed)) | 16'h8001;
		prog.delete();
		prog.push_back(encode_i(OP_ADDI, 0, 1, imm));
		for (int i = 0; i < 4; i++)
		begin
			prog.push_back(encode_r(F_SLL, 0, 1, 14 + i, shamts[i]));
			prog.push_back(encode_r(F_SRL, 0, 1, 18 + i, shamts[i]));
		end
		execute_and_check(prog.size());
		finish_test();
	endtask

	task automatic test_memory();
		logic [15:0] hi;
		logic [15:0] lo;
		start_test("memory");
		// Both halves negative so sign and zero extension differ
		hi = 16'($random(seed)) | 16'h8000;
		lo = 16'($random(seed)) | 16'h8000;
		prog.delete();
		prog.push_back(encode_i(OP_ADDI, 0, 20, 16'h0040));
		prog.push_back(encode_i(OP_ADDI, 0, 21, hi));
		prog.push_back(encode_r(F_SLL, 0, 21, 21, 16));
		prog.push_back(encode_i(OP_ADDI, 0, 22, lo));
		prog.push_back(encode_r(F_SLL, 0, 22, 22, 16));
		prog.push_back(encode_r(F_SRL, 0, 22, 22, 16));
		prog.push_back(encode_r(F_OR, 21, 22, 21, 0));
		prog.push_back(encode_i(OP_SW, 20, 21, 16'h0004));
		prog.push_back(encode_i(OP_LW, 20, 23, 16'h0004));
		prog.push_back(encode_i(OP_LH, 20, 24, 16'h0004));
		prog.push_back(encode_i(OP_LH, 20, 25, 16'h0006));
		prog.push_back(encode_i(OP_LHU, 20, 26, 16'h0004));
		prog.push_back(encode_i(OP_LHU, 20, 27, 16'h0006));
		execute_and_check(prog.size());
		finish_test();
	endtask

	task automatic test_branch();
		start_test("branch");
		prog.delete();
		prog.push_back(encode_i(OP_ADDI, 0, 1, 16'h0005));
		prog.push_back(encode_i(OP_ADDI, 0, 2, 16'h0005));
		prog.push_back(encode_i(OP_BEQ, 1, 2, 16'h0002));
		prog.push_back(encode_i(OP_ADDI, 0, 3, 16'h0011));
		prog.push_back(encode_i(OP_ADDI, 0, 4, 16'h0022));
		prog.push_back(encode_i(OP_ADDI, 0, 5, 16'h0033));
		prog.push_back(encode_i(OP_BEQ, 1, 0, 16'h0002));
		prog.push_back(encode_i(OP_ADDI, 0, 6, 16'h0044));
		prog.push_back(encode_i(OP_ADDI, 0, 7, 16'h0055));
		prog.push_back(32'h0);
		// Ten words, one skipped by the taken branch
		execute_and_check(9);
		finish_test();
	endtask

	task automatic test_zero_and_unknown();
		start_test("zero_unknown");
		prog.delete();
		prog.push_back(encode_i(OP_ADDI, 0, 0, 16'h007b));
		prog.push_back(encode_r(F_OR, 1, 2, 0, 0));
		prog.push_back({6'h3f, 5'd1, 5'd5, 16'h1234});
		prog.push_back({6'h02, 5'd3, 5'd6, 16'hbeef});
		prog.push_back(32'h0);
		execute_and_check(prog.size());
		finish_test();
	endtask

	task automatic test_freeze();
		start_test("freeze");
		prog.delete();
		for (int i = 0; i < 6; i++)
			prog.push_back(encode_i(OP_ADDI, 0, 8 + i, 16'($random(seed))));
		load_program();
		run_instructions(3);
		check_registers();
		// Second pass spans 32 more idle cycles
		check_registers();
		run_instructions(3);
		check_registers();
		finish_test();
	endtask

	initial
	begin
		seed        = 32'h8dce;
		run         = 1'b0;
		imem_we     = 1'b0;
		imem_addr   = '0;
		imem_data   = '0;
		dbg_addr    = '0;
		error_count = 0;
		tests_run   = 0;
		test_errors = 0;
		test_name   = "";
		foreach (model_regs[i])
			model_regs[i] = 32'h0;
		model_pc  = `MIPS_RESET_PC;
		model_npc = model_pc + 32'd4;

		wait_reset_release();
		test_reset_state();
		test_arith();
		test_shifts();
		test_memory();
		test_branch();
		test_zero_and_unknown();
		test_freeze();

		$display("Summary: %0d tests, %0d errors", tests_run, error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/main_control.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/data_mem.sv
hw/mips_core.sv
verif/tb_clock.sv
verif/tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - include_dirs:
      - include
    files:
      - hw/isa_pkg.sv
      - hw/ctrl_pkg.sv
      - hw/main_control.sv
      - hw/fetch_unit.sv
      - hw/reg_file.sv
      - hw/alu.sv
      - hw/data_mem.sv
      - hw/mips_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_clock.sv
      - verif/tb_mips_core.sv
